//--- Makefile
# Verilator build and run of the check-node unit testbench.

TOP     = cnode_unit_tb
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module $(TOP) --Mdir $(OBJ_DIR) -f cnode_unit.f

# The log decides the result; a missing pass line means the run died early.
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- cnode_unit.f
verilog/cnode_pkg.sv
verilog/vnode_msg_if.sv
verilog/cnode_min_search.sv
verilog/cnode_sign_buffer.sv
verilog/cnode_restore.sv
verilog/cnode_unit.sv
verif/cnode_unit_tb.sv

//--- verif/cnode_unit_tb.sv
/* Testbench for the check-node unit. Row table with a reference model,
   falling-edge driver, output monitor, watchdog and clock. */

module cnode_unit_tb
  import cnode_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_DIRECTED    = 8;    // Hand-written rows, sent back to back.
  localparam int NUM_RANDOM      = 24;   // LFSR rows, sent with enable gaps.
  localparam int NUM_ROWS        = NUM_DIRECTED + NUM_RANDOM;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * ROW_DEG * 4 + 200;
  localparam int MAG_LIMIT       = (1 << MAG_W) - 1;  // Largest magnitude, 15.
  localparam int LATENCY         = 3;    // Last input to first output, enabled cycles.

  logic       iclk;
  logic       ireset;
  logic       iclkena;
  logic       istart;
  logic       ival;
  node_t      ivnode;
  logic       ivnode_mask;
  cnode_ctx_t icnode_ctx;
  logic       ocnode_val;
  node_t      ocnode;
  cnode_ctx_t ocnode_ctx;

  //##########################################################################
  // Row table, expected queues and bookkeeping.
  //##########################################################################

  int               row_msg  [NUM_ROWS][ROW_DEG];  // Input messages.
  logic [ROW_DEG-1:0] row_mask [NUM_ROWS];         // Bit c masks column c.
  logic             row_mz   [NUM_ROWS];           // mask_zero of the row.
  int               row_exp  [NUM_ROWS][ROW_DEG];  // Expected outputs from the model.

  int         exp_val_q[$];    // Expected outputs in arrival order.
  cnode_ctx_t exp_ctx_q[$];
  int         exp_row_q[$];
  int         last_edge_q[$];  // Enabled edge that took each row's last input.

  logic [15:0] lfsr;
  int          en_cnt;         // Enabled clock edges so far.
  logic        en_at_edge;     // Enable seen at the latest rising edge.
  int          out_col;        // Column of the next output inside its row.
  int          prev_edge;
  int          outputs;
  int          checks;
  int          errors;

  cnode_unit u_cnode_unit (
    .iclk        (iclk),
    .ireset      (ireset),
    .iclkena     (iclkena),
    .istart      (istart),
    .ival        (ival),
    .ivnode      (ivnode),
    .ivnode_mask (ivnode_mask),
    .icnode_ctx  (icnode_ctx),
    .ocnode_val  (ocnode_val),
    .ocnode      (ocnode),
    .ocnode_ctx  (ocnode_ctx)
  );

  initial iclk = 1'b0;
  always #4 iclk = ~iclk;  // 8 ns period.

  // Taps 16, 14, 13, 11 give a maximal length sequence.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken.
  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic check_value(input string what, input logic signed [31:0] got,
                             input logic signed [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("FAILED at %0d ns: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  // Min-sum reference for one row. min2 is the smallest magnitude outside the min1 column.
  task automatic compute_expected(input int r);
    int mag [ROW_DEG];
    int found;
    int min1;
    int min2;
    int min1_col;
    int prod;
    int n1;
    int n2;
    int m;
    int sgn;
    found    = 0;
    min1     = MAG_LIMIT + 1;   // Above any magnitude, so a lone 15 still wins.
    min1_col = 0;
    prod     = 0;
    // On a tie the earlier column keeps min1.
    for (int c = 0; c < ROW_DEG; c++) begin
      mag[c] = (row_msg[r][c] < 0) ? -row_msg[r][c] : row_msg[r][c];
      if (mag[c] > MAG_LIMIT) mag[c] = MAG_LIMIT;  // -16 clips to 15.
      if (!row_mask[r][c]) begin
        found++;
        prod = prod ^ int'(row_msg[r][c] < 0);
        if (mag[c] < min1) begin
          min1     = mag[c];
          min1_col = c;
        end
      end
    end
    min2 = MAG_LIMIT + 1;
    for (int c = 0; c < ROW_DEG; c++) begin
      if (!row_mask[r][c] && (c != min1_col) && (mag[c] < min2)) min2 = mag[c];
    end
    // Scale by 6/8 and round down; minima never found stay at the maximum.
    n1 = (found > 0) ? (min1 * NORM_FACTOR) / 8 : MAG_LIMIT;
    n2 = (found > 1) ? (min2 * NORM_FACTOR) / 8 : MAG_LIMIT;
    for (int c = 0; c < ROW_DEG; c++) begin
      m   = (c == min1_col) ? n2 : n1;
      sgn = prod ^ int'(row_msg[r][c] < 0);
      if (row_mask[r][c] && row_mz[r]) row_exp[r][c] = 0;
      else row_exp[r][c] = (sgn != 0) ? -m : m;
    end
  endtask

  //##########################################################################
  // Driver. Inputs change on the falling edge only.
  //##########################################################################

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge iclk);
      iclkena = 1'b1;
      ival    = 1'b0;
      istart  = 1'b0;
    end
  endtask

  task automatic apply_row(input int r, input bit gaps);
    int         c;
    int         bits;
    bit         en;
    bit         skip;
    cnode_ctx_t ctx;
    ctx.row_tag   = TAG_W'(r);  // Tag wraps every 16 rows.
    ctx.mask_zero = row_mz[r];
    for (int k = 0; k < ROW_DEG; k++) begin
      exp_val_q.push_back(row_exp[r][k]);
      exp_ctx_q.push_back(ctx);
      exp_row_q.push_back(r);
    end
    c = 0;
    while (c < ROW_DEG) begin
      @(negedge iclk);
      en   = 1'b1;
      skip = 1'b0;
      if (gaps) begin
        take_bits(2, bits);
        en = (bits != 0);                 // Enable low on about a quarter of cycles.
        take_bits(3, bits);
        skip = (bits == 0) && (c != 0);   // Occasional hole inside the row.
      end
      iclkena = en;
      if (en && !skip) begin
        ival        = 1'b1;
        istart      = (c == 0);
        ivnode      = node_t'(row_msg[r][c]);
        ivnode_mask = row_mask[r][c];
        icnode_ctx  = ctx;
        if (c == ROW_DEG - 1) last_edge_q.push_back(en_cnt + 1);
        c++;
      end
      else begin
        ival   = 1'b0;
        istart = 1'b0;
      end
    end
  endtask

  //##########################################################################
  // Monitor. Outputs are read at the falling edge after an enabled edge.
  //##########################################################################

  always @(posedge iclk) begin
    en_at_edge = iclkena;
    if (iclkena) en_cnt++;
  end

  always @(negedge iclk) begin
    if (!ireset && en_at_edge && ocnode_val) begin
      outputs++;
      if (exp_val_q.size() == 0) begin
        errors++;
        $display("Unexpected output at %0d ns with no row pending", $time);
      end
      else begin
        check_value($sformatf("row %0d col %0d ocnode", exp_row_q[0], out_col),
                    32'(ocnode), exp_val_q.pop_front());
        check_value($sformatf("row %0d col %0d ocnode_ctx", exp_row_q[0], out_col),
                    32'(ocnode_ctx), 32'(exp_ctx_q.pop_front()));
        if (out_col == 0) begin
          if (last_edge_q.size() == 0) begin
            errors++;
            $display("Row %0d started output before its last input", exp_row_q[0]);
          end
          else begin
            check_value($sformatf("row %0d latency", exp_row_q[0]),
                        en_cnt + 1 - last_edge_q.pop_front(), LATENCY);
          end
        end
        else begin
          check_value($sformatf("row %0d col %0d spacing", exp_row_q[0], out_col),
                      en_cnt, prev_edge + 1);  // Outputs of a row are consecutive.
        end
        void'(exp_row_q.pop_front());
        prev_edge = en_cnt;
        out_col   = (out_col == ROW_DEG - 1) ? 0 : out_col + 1;
      end
    end
  end

  // Ends a run that stops making progress.
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge iclk);
    $display("Timeout after %0d cycles with %0d outputs still missing",
             WATCHDOG_CYCLES, exp_val_q.size());
    $display("Test failures found");
    $finish;
  end

  //##########################################################################
  // Stimulus table and main sequence.
  //##########################################################################

  initial begin
    int bits;
    ireset      = 1'b1;
    iclkena     = 1'b0;
    istart      = 1'b0;
    ival        = 1'b0;
    ivnode      = '0;
    ivnode_mask = 1'b0;
    icnode_ctx  = '0;
    en_cnt      = 0;
    en_at_edge  = 1'b0;
    out_col     = 0;
    prev_edge   = 0;
    outputs     = 0;
    checks      = 0;
    errors      = 0;
    lfsr        = 16'd95;

    row_msg[0] = '{3, -7, 5, 9, -2, 12, -6, 4};          // Distinct magnitudes.
    row_mask[0] = 8'h00;
    row_mz[0] = 1'b0;
    row_msg[1] = '{-16, 15, -16, 14, 13, -15, 11, 15};   // Clipping and 6/8 round down.
    row_mask[1] = 8'h00;
    row_mz[1] = 1'b0;
    row_msg[2] = '{-16, -16, -16, -16, -16, -16, -16, -16};
    row_mask[2] = 8'h00;
    row_mz[2] = 1'b1;
    row_msg[3] = '{1, -9, 6, -3, 8, 10, -12, 7};         // Columns 0 and 3 masked.
    row_mask[3] = 8'b0000_1001;
    row_mz[3] = 1'b1;
    row_msg[4] = '{1, -9, 6, -3, 8, 10, -12, 7};         // Same, masked ones restored.
    row_mask[4] = 8'b0000_1001;
    row_mz[4] = 1'b0;
    row_msg[5] = '{-1, 2, -3, 4, -5, 6, -7, 8};          // Nothing left unmasked.
    row_mask[5] = 8'hFF;
    row_mz[5] = 1'b0;
    row_msg[6] = '{5, -4, 7, -1, 9, 10, -2, 3};          // A single unmasked column.
    row_mask[6] = 8'b1110_1111;
    row_mz[6] = 1'b1;
    row_msg[7] = '{-5, 5, -5, 5, -5, 5, -5, 5};          // Equal magnitudes.
    row_mask[7] = 8'h00;
    row_mz[7] = 1'b0;

    for (int r = NUM_DIRECTED; r < NUM_ROWS; r++) begin
      for (int c = 0; c < ROW_DEG; c++) begin
        take_bits(5, bits);
        row_msg[r][c] = int'(node_t'(bits));
        take_bits(3, bits);
        row_mask[r][c] = (bits == 0);
      end
      take_bits(1, bits);
      row_mz[r] = 1'(bits);
    end
    for (int r = 0; r < NUM_ROWS; r++) compute_expected(r);

    repeat (5) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;

    for (int r = 0; r < NUM_ROWS; r++) begin
      if (r == NUM_DIRECTED) idle_cycles(4);
      if (r >= NUM_DIRECTED) begin
        take_bits(2, bits);
        idle_cycles(bits);  // Random rows may also follow each other directly.
      end
      apply_row(r, r >= NUM_DIRECTED);
    end

    // Flush the pipeline, then watch a while for stray outputs.
    idle_cycles(1);
    while (exp_val_q.size() != 0) @(negedge iclk);
    idle_cycles(2 * ROW_DEG);
    check_value("outputs received", outputs, NUM_ROWS * ROW_DEG);
    check_value("rows without output", last_edge_q.size(), 0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end
    else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- verilog/cnode_min_search.sv
/* Input stage of the check-node unit. Finds both minima, their column and the
   sign product of each row, normalizes them and forwards signs and masks. */

module cnode_min_search
  import cnode_pkg::*;
(
  input  logic        iclk,
  input  logic        ireset,
  input  logic        iclkena,
  input  logic        istart,
  input  logic        ival,
  input  node_t       ivnode,
  input  logic        ivnode_mask,
  input  cnode_ctx_t  icnode_ctx,
  vnode_msg_if.source wr_msg,
  output logic        min_val,
  output vn_min_t     vn_min,
  output cnode_ctx_t  min_ctx
);

  search_state_t state;
  col_idx_t      col_cnt;     // Column of the next message.
  vn_min_t       acc;         // Running minima of the row.
  logic [1:0]    found;       // Unmasked entries seen so far, saturating at 2.
  cnode_ctx_t    ctx_q;       // Context captured with istart.

  logic          accept;
  logic          last_col;
  col_idx_t      cur_col;
  cnode_ctx_t    cur_ctx;
  vn_min_t       base;
  vn_min_t       upd;
  logic [1:0]    base_found;
  logic [1:0]    upd_found;
  vnode_t        cur_mag;

  // Magnitude of a message; -16 has no 4-bit magnitude and clips to 15.
  function automatic vnode_t sat_abs(input node_t v);
    logic [NODE_W-1:0] a;
    a = v[NODE_W-1] ? -v : v;
    return a[NODE_W-1] ? MAG_MAX : a[MAG_W-1:0];
  endfunction

  // Multiply by NORM_FACTOR and drop the fraction, so the result rounds down.
  function automatic vnode_t normalize(input vnode_t m);
    logic [SCALE_W-1:0] prod;
    prod = SCALE_W'(m) * SCALE_W'(NORM_FACTOR);
    return vnode_t'(prod >> NORM_SHIFT);
  endfunction

  //##########################################################################
  // Search step for the message on the input.
  //##########################################################################

  always_comb begin
    accept     = ival & (istart | (state == COLLECT));  // Stray messages in IDLE are dropped.
    cur_col    = istart ? '0 : col_cnt;
    cur_ctx    = istart ? icnode_ctx : ctx_q;
    last_col   = (cur_col == col_idx_t'(ROW_DEG - 1));
    cur_mag    = sat_abs(ivnode);
    // A new row starts from empty minima.
    base       = istart ? vn_min_t'{min1: MAG_MAX, min2: MAG_MAX,
                                    min1_col: '0, prod_sign: 1'b0} : acc;
    base_found = istart ? 2'd0 : found;
    upd        = base;
    upd_found  = base_found;
    if (!ivnode_mask) begin
      upd.prod_sign = base.prod_sign ^ ivnode[NODE_W-1];
      if (base_found != 2'd2) begin
        upd_found = base_found + 2'd1;
      end
      // The found count keeps a magnitude of 15 from losing against the empty value.
      if ((base_found == 2'd0) || (cur_mag < base.min1)) begin
        upd.min2     = base.min1;
        upd.min1     = cur_mag;
        upd.min1_col = cur_col;
      end
      else if ((base_found == 2'd1) || (cur_mag < base.min2)) begin
        upd.min2 = cur_mag;
      end
    end
  end

  //##########################################################################
  // Registers.
  //##########################################################################

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state      <= IDLE;
      col_cnt    <= '0;
      found      <= '0;
      min_val    <= 1'b0;
      wr_msg.val <= 1'b0;
    end
    else if (iclkena) begin
      wr_msg.val <= accept;              // Every accepted entry goes to the sign buffer.
      min_val    <= accept & last_col;   // One pulse per finished row.
      if (accept) begin
        col_cnt <= cur_col + 1'b1;       // Wraps to zero after the last column.
        found   <= upd_found;
        state   <= last_col ? IDLE : COLLECT;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && accept) begin
      acc           <= upd;
      ctx_q         <= cur_ctx;
      wr_msg.start  <= istart;
      wr_msg.idx    <= cur_col;
      wr_msg.sign   <= ivnode[NODE_W-1];
      wr_msg.mask   <= ivnode_mask;
      if (last_col) begin
        // Minima that were never found are passed on unscaled at the maximum.
        vn_min.min1      <= (upd_found != 2'd0) ? normalize(upd.min1) : MAG_MAX;
        vn_min.min2      <= (upd_found == 2'd2) ? normalize(upd.min2) : MAG_MAX;
        vn_min.min1_col  <= upd.min1_col;
        vn_min.prod_sign <= upd.prod_sign;
        min_ctx          <= cur_ctx;
      end
    end
  end

  // A new row may only begin once the previous row has all ROW_DEG entries.
  a_start_on_full_row : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && ival && istart) |-> (state == IDLE)
  );

endmodule

//--- verilog/cnode_pkg.sv
/* Widths, row degree and normalization constants of the check-node unit,
   with the message, minima and context types and the search state enum. */

package cnode_pkg;

  //##########################################################################
  // Sizes.
  //##########################################################################

  localparam int NODE_W      = 5;            // Signed message width.
  localparam int MAG_W       = NODE_W - 1;   // Magnitude width.
  localparam int ROW_DEG     = 8;            // Messages in one row.
  localparam int COL_W       = 3;            // Enough bits to index ROW_DEG columns.
  localparam int TAG_W       = 4;            // Row tag carried through the unit.

  // Minima are scaled by NORM_FACTOR / 2**NORM_SHIFT, that is 6/8.
  localparam int NORM_FACTOR = 6;
  localparam int NORM_SHIFT  = 3;
  localparam int SCALE_W     = MAG_W + NORM_SHIFT;  // Holds 15 * 6 without overflow.

  //##########################################################################
  // Types.
  //##########################################################################

  typedef logic signed [NODE_W-1:0] node_t;     // Two's-complement message.
  typedef logic        [MAG_W-1:0]  vnode_t;    // Unsigned magnitude.
  typedef logic        [COL_W-1:0]  col_idx_t;  // Column inside a row.

  // Largest magnitude, also the value of a minimum that was never found.
  localparam vnode_t MAG_MAX = {MAG_W{1'b1}};

  // Result of the minimum search over one row.
  typedef struct packed {
    vnode_t   min1;       // Smallest magnitude.
    vnode_t   min2;       // Second smallest magnitude.
    col_idx_t min1_col;   // Column where min1 was seen.
    logic     prod_sign;  // XOR of all unmasked signs.
  } vn_min_t;

  // Per-row context that travels with the data.
  typedef struct packed {
    logic [TAG_W-1:0] row_tag;    // Free tag, returned with the outputs.
    logic             mask_zero;  // Force masked outputs to zero.
  } cnode_ctx_t;

  // The search is idle between rows and collecting inside one.
  typedef enum logic {
    IDLE    = 1'b0,
    COLLECT = 1'b1
  } search_state_t;

endpackage

//--- verilog/cnode_restore.sv
/* Output stage of the check-node unit. Rebuilds each signed check-node
   message from the row minima and the sign of its own column. */

module cnode_restore
  import cnode_pkg::*;
(
  input  logic        iclk,
  input  logic        ireset,
  input  logic        iclkena,
  vnode_msg_if.sink   rd_msg,
  input  vn_min_t     rd_min,
  input  cnode_ctx_t  rd_ctx,
  output logic        ocnode_val,
  output cnode_ctx_t  ocnode_ctx,
  output node_t       ocnode
);

  // Pick the magnitude and apply the sign by two's-complement negation.
  function automatic node_t unpack_cnode(input vnode_t min1,
                                         input vnode_t min2,
                                         input logic   min2_sel,
                                         input logic   sign);
    vnode_t            cn_abs;
    logic [NODE_W-1:0] mag_ext;
    cn_abs  = min2_sel ? min2 : min1;   // The min1 column must not see itself.
    mag_ext = {1'b0, cn_abs};
    return node_t'((mag_ext ^ {NODE_W{sign}}) + NODE_W'(sign));
  endfunction

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ocnode_val <= 1'b0;
    end
    else if (iclkena) begin
      ocnode_val <= rd_msg.val;  // One cycle behind the replay.
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (rd_msg.start) begin
        ocnode_ctx <= rd_ctx;    // Context is constant over a row.
      end
      if (rd_msg.mask && rd_ctx.mask_zero) begin
        ocnode <= '0;
      end
      else begin
        ocnode <= unpack_cnode(rd_min.min1, rd_min.min2,
                               (rd_min.min1_col == rd_msg.idx),
                               rd_min.prod_sign ^ rd_msg.sign);
      end
    end
  end

endmodule

//--- verilog/cnode_sign_buffer.sv
/* Two-bank store of per-column signs and masks. A finished row is replayed
   column by column together with its minima and context. */

module cnode_sign_buffer
  import cnode_pkg::*;
(
  input  logic        iclk,
  input  logic        ireset,
  input  logic        iclkena,
  vnode_msg_if.sink   wr_msg,
  input  logic        min_val,
  input  vn_min_t     vn_min,
  input  cnode_ctx_t  min_ctx,
  vnode_msg_if.source rd_msg,
  output vn_min_t     rd_min,
  output cnode_ctx_t  rd_ctx
);

  logic [1:0][ROW_DEG-1:0] sign_mem;   // Bank, then column.
  logic [1:0][ROW_DEG-1:0] mask_mem;

  logic       wr_bank;     // Bank of the row being written.
  logic       wr_sel;      // Bank this entry goes to.
  logic       rd_bank;     // Bank being replayed.
  logic       rd_active;
  col_idx_t   rd_cnt;
  logic [1:0] bank_busy;   // Bank holds a row that is not yet fully replayed.
  logic       rd_last;

  assign wr_sel  = (wr_msg.val & wr_msg.start) ? ~wr_bank : wr_bank;  // Swap on row start.
  assign rd_last = rd_active & (rd_cnt == col_idx_t'(ROW_DEG - 1));

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_bank   <= 1'b0;
      rd_bank   <= 1'b0;
      rd_active <= 1'b0;
      rd_cnt    <= '0;
      bank_busy <= '0;      // Both banks empty.
    end
    else if (iclkena) begin
      if (wr_msg.val) begin
        wr_bank <= wr_sel;
      end
      // A new replay may start on the very cycle the previous one ends.
      if (min_val) begin
        rd_active <= 1'b1;
        rd_cnt    <= '0;
        rd_bank   <= wr_bank;
      end
      else if (rd_active) begin
        rd_cnt <= rd_cnt + 1'b1;
        if (rd_last) begin
          rd_active <= 1'b0;
        end
      end
      for (int b = 0; b < 2; b++) begin
        if (rd_last && (rd_bank == 1'(b))) begin
          bank_busy[b] <= 1'b0;
        end
        if (wr_msg.val && wr_msg.start && (wr_sel == 1'(b))) begin
          bank_busy[b] <= 1'b1;
        end
      end
    end
  end

  // Storage and latched row data.
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (wr_msg.val) begin
        sign_mem[wr_sel][wr_msg.idx] <= wr_msg.sign;
        mask_mem[wr_sel][wr_msg.idx] <= wr_msg.mask;
      end
      if (min_val) begin
        rd_min <= vn_min;   // Held for the whole replay.
        rd_ctx <= min_ctx;
      end
    end
  end

  assign rd_msg.val   = rd_active;
  assign rd_msg.start = rd_active & (rd_cnt == '0);
  assign rd_msg.idx   = rd_cnt;
  assign rd_msg.sign  = sign_mem[rd_bank][rd_cnt];
  assign rd_msg.mask  = mask_mem[rd_bank][rd_cnt];

  // Rows arriving too fast would overwrite a bank under replay.
  a_no_write_to_replay : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && wr_msg.val) |-> !(rd_active && (wr_sel == rd_bank))
  );

  // A row must not open a bank whose previous row is still pending.
  a_start_on_free_bank : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && wr_msg.val && wr_msg.start) |-> !bank_busy[wr_sel]
  );

endmodule

//--- verilog/cnode_unit.sv
/* Top level of the min-sum check-node unit. Connects the min search, the
   sign buffer and the restore stage. */

module cnode_unit
  import cnode_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  input  logic       iclkena,
  input  logic       istart,
  input  logic       ival,
  input  node_t      ivnode,
  input  logic       ivnode_mask,
  input  cnode_ctx_t icnode_ctx,
  output logic       ocnode_val,
  output node_t      ocnode,
  output cnode_ctx_t ocnode_ctx
);

  vnode_msg_if wr_msg ();   // Signs and masks of accepted inputs.
  vnode_msg_if rd_msg ();   // Replayed row.

  logic       min_val;
  vn_min_t    vn_min;
  cnode_ctx_t min_ctx;
  vn_min_t    rd_min;
  cnode_ctx_t rd_ctx;

  //##########################################################################
  // Search, then buffer, then restore.
  //##########################################################################

  cnode_min_search u_min_search (
    .iclk        (iclk),
    .ireset      (ireset),
    .iclkena     (iclkena),
    .istart      (istart),
    .ival        (ival),
    .ivnode      (ivnode),
    .ivnode_mask (ivnode_mask),
    .icnode_ctx  (icnode_ctx),
    .wr_msg      (wr_msg.source),
    .min_val     (min_val),
    .vn_min      (vn_min),
    .min_ctx     (min_ctx)
  );

  cnode_sign_buffer u_sign_buffer (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .wr_msg  (wr_msg.sink),
    .min_val (min_val),
    .vn_min  (vn_min),
    .min_ctx (min_ctx),
    .rd_msg  (rd_msg.source),
    .rd_min  (rd_min),
    .rd_ctx  (rd_ctx)
  );

  cnode_restore u_restore (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .rd_msg     (rd_msg.sink),
    .rd_min     (rd_min),
    .rd_ctx     (rd_ctx),
    .ocnode_val (ocnode_val),
    .ocnode_ctx (ocnode_ctx),
    .ocnode     (ocnode)
  );

endmodule

//--- verilog/vnode_msg_if.sv
/* Per-column message stream between the check-node stages. */

interface vnode_msg_if
  import cnode_pkg::*;
();

  logic     val;    // Entry is valid on this enabled cycle.
  logic     start;  // First entry of a row.
  col_idx_t idx;    // Column of the entry.
  logic     sign;   // Sign of the variable-node message.
  logic     mask;   // Entry is masked out of the row.

  // Stage that produces the stream.
  modport source (
    output val, start, idx, sign, mask
  );

  // Stage that consumes it.
  modport sink (
    input  val, start, idx, sign, mask
  );

endinterface
